// ==== include/icb_bus_macros.svh ====
// ICB 1-to-4 bus parameters
// Bus widths, slave port count, pending response depth and address map
`ifndef ICB_BUS_MACROS_SVH
`define ICB_BUS_MACROS_SVH

`define ICB_AW          32
`define ICB_DW          64
`define ICB_MW          8
`define ICB_SLV_NUM     4
`define ICB_OUTS_DEPTH  2

// Region bases for ports 0 to 2, port 3 takes the rest
`define ICB_O0_BASE     32'h1000_0000
`define ICB_O1_BASE     32'h2000_0000
`define ICB_O2_BASE     32'h3000_0000
`define ICB_REGION_LSB  12

`endif

// ==== src/icb_bus_pkg.sv ====
// ICB bus types
// Command and response payloads carried through the splitter,
// plus the one-hot slave port select
`include "icb_bus_macros.svh"

package icb_bus_pkg;

  typedef struct packed {
    logic               read;
    logic [`ICB_AW-1:0] addr;
    logic [`ICB_DW-1:0] wdata;
    logic [`ICB_MW-1:0] wmask;
  } icb_cmd_t;

  typedef struct packed {
    logic [`ICB_DW-1:0] rdata;
    logic               err;
  } icb_rsp_t;

  // One bit per slave port
  typedef logic [`ICB_SLV_NUM-1:0] slv_sel_t;

endpackage

// ==== src/icb_pipe_stage.sv ====
// ICB pipe stage
// One-entry valid/ready register stage. Accepts a new item in the same
// cycle the held one leaves, so a full stream passes without bubbles.
`timescale 1ns/1ps

module icb_pipe_stage
  import icb_bus_pkg::*;
#(
  parameter type PAYLOAD_T = icb_cmd_t
) (
  input  logic     clk,
  input  logic     i_rst_n,
  input  logic     i_valid,
  output logic     o_ready,
  input  PAYLOAD_T i_data,
  output logic     o_valid,
  input  logic     i_ready,
  output PAYLOAD_T o_data,
  output logic     o_full
);

  logic     valid_q;
  PAYLOAD_T data_q;
  logic     in_xfer;

  // Free when empty or when the held entry leaves this cycle
  assign o_ready = ~valid_q | i_ready;
  assign in_xfer = i_valid & o_ready;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (in_xfer) begin
      valid_q <= 1'b1;
    end else if (i_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      data_q <= i_data;
    end
  end

  assign o_valid = valid_q;
  assign o_data  = data_q;
  assign o_full  = valid_q;

endmodule

// ==== src/icb_addr_decode.sv ====
// ICB address decoder
// Matches the address against three base regions in priority order,
// port 0 highest. Disabled or unmatched addresses go to port 3.
`timescale 1ns/1ps
`include "icb_bus_macros.svh"

module icb_addr_decode
  import icb_bus_pkg::*;
(
  input  logic [`ICB_AW-1:0]      i_addr,
  input  logic [`ICB_SLV_NUM-2:0] i_slv_enable,
  output slv_sel_t                o_sel
);

  localparam logic [`ICB_AW-1:0] BASE0 = `ICB_O0_BASE;
  localparam logic [`ICB_AW-1:0] BASE1 = `ICB_O1_BASE;
  localparam logic [`ICB_AW-1:0] BASE2 = `ICB_O2_BASE;

  logic hit0;
  logic hit1;
  logic hit2;

  assign hit0 = (i_addr[`ICB_AW-1:`ICB_REGION_LSB] == BASE0[`ICB_AW-1:`ICB_REGION_LSB])
              & i_slv_enable[0];
  assign hit1 = (i_addr[`ICB_AW-1:`ICB_REGION_LSB] == BASE1[`ICB_AW-1:`ICB_REGION_LSB])
              & i_slv_enable[1] & ~hit0;
  assign hit2 = (i_addr[`ICB_AW-1:`ICB_REGION_LSB] == BASE2[`ICB_AW-1:`ICB_REGION_LSB])
              & i_slv_enable[2] & ~hit0 & ~hit1;

  // Default port
  assign o_sel = {~(hit0 | hit1 | hit2), hit2, hit1, hit0};

endmodule

// ==== src/icb_splt.sv ====
// ICB command splitter
// Routes each command to its selected slave port and records the port
// in a small queue. Responses are taken only from the port at the head
// of the queue, so they come back in command order.
`timescale 1ns/1ps
`include "icb_bus_macros.svh"

module icb_splt
  import icb_bus_pkg::*;
(
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_cmd_valid,
  output logic               o_cmd_ready,
  input  icb_cmd_t           i_cmd,
  input  slv_sel_t           i_sel,
  output logic               o_rsp_valid,
  input  logic               i_rsp_ready,
  output icb_rsp_t           o_rsp,
  output logic               o_slv_cmd_valid [`ICB_SLV_NUM],
  input  logic               i_slv_cmd_ready [`ICB_SLV_NUM],
  output logic               o_slv_cmd_read  [`ICB_SLV_NUM],
  output logic [`ICB_AW-1:0] o_slv_cmd_addr  [`ICB_SLV_NUM],
  output logic [`ICB_DW-1:0] o_slv_cmd_wdata [`ICB_SLV_NUM],
  output logic [`ICB_MW-1:0] o_slv_cmd_wmask [`ICB_SLV_NUM],
  output logic               o_slv_rsp_ready [`ICB_SLV_NUM],
  input  logic               i_slv_rsp_valid [`ICB_SLV_NUM],
  input  logic [`ICB_DW-1:0] i_slv_rsp_rdata [`ICB_SLV_NUM],
  input  logic               i_slv_rsp_err   [`ICB_SLV_NUM],
  output logic               o_busy
);

  localparam int DEPTH = `ICB_OUTS_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  slv_sel_t         q_sel [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] q_cnt;
  logic             q_full;
  logic             q_empty;
  slv_sel_t         head_sel;
  logic             sel_ready;
  logic             head_valid;
  logic             cmd_push;
  logic             rsp_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign q_full   = (q_cnt == CNT_W'(DEPTH));
  assign q_empty  = (q_cnt == '0);
  assign head_sel = q_sel[rd_ptr];

  // Ready of the selected port and response mux from the head port
  always_comb begin
    sel_ready  = 1'b0;
    head_valid = 1'b0;
    o_rsp      = '0;
    for (int k = 0; k < `ICB_SLV_NUM; k++) begin
      sel_ready  = sel_ready | (i_sel[k] & i_slv_cmd_ready[k]);
      head_valid = head_valid | (head_sel[k] & i_slv_rsp_valid[k]);
      if (head_sel[k]) begin
        o_rsp.rdata = i_slv_rsp_rdata[k];
        o_rsp.err   = i_slv_rsp_err[k];
      end
    end
  end

  // Payload goes to every port, valid only to the selected one
  always_comb begin
    for (int k = 0; k < `ICB_SLV_NUM; k++) begin
      o_slv_cmd_valid[k] = i_cmd_valid & i_sel[k] & ~q_full;
      o_slv_cmd_read[k]  = i_cmd.read;
      o_slv_cmd_addr[k]  = i_cmd.addr;
      o_slv_cmd_wdata[k] = i_cmd.wdata;
      o_slv_cmd_wmask[k] = i_cmd.wmask;
      o_slv_rsp_ready[k] = i_rsp_ready & head_sel[k] & ~q_empty;
    end
  end

  assign o_cmd_ready = sel_ready & ~q_full;
  assign o_rsp_valid = head_valid & ~q_empty;
  assign cmd_push    = i_cmd_valid & o_cmd_ready;
  assign rsp_pop     = o_rsp_valid & i_rsp_ready;
  assign o_busy      = ~q_empty;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_cnt  <= '0;
    end else begin
      if (cmd_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rsp_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (cmd_push & ~rsp_pop) begin
        q_cnt <= q_cnt + 1'b1;
      end else if (rsp_pop & ~cmd_push) begin
        q_cnt <= q_cnt - 1'b1;
      end
    end
  end

  // Port of each pending response
  always_ff @(posedge clk) begin
    if (cmd_push) begin
      q_sel[wr_ptr] <= i_sel;
    end
  end

endmodule

// ==== src/icb_1to4_bus.sv ====
// ICB 1-to-4 bus
// Master commands pass a one-entry buffer, are decoded by address and
// split to four slave ports. Responses return in order through a
// one-entry response buffer.
`timescale 1ns/1ps
`include "icb_bus_macros.svh"

module icb_1to4_bus
  import icb_bus_pkg::*;
(
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  logic                    i_icb_cmd_valid,
  output logic                    o_icb_cmd_ready,
  input  logic                    i_icb_cmd_read,
  input  logic [`ICB_AW-1:0]      i_icb_cmd_addr,
  input  logic [`ICB_DW-1:0]      i_icb_cmd_wdata,
  input  logic [`ICB_MW-1:0]      i_icb_cmd_wmask,
  output logic                    o_icb_rsp_valid,
  input  logic                    i_icb_rsp_ready,
  output logic [`ICB_DW-1:0]      o_icb_rsp_rdata,
  output logic                    o_icb_rsp_err,
  input  logic [`ICB_SLV_NUM-2:0] i_slv_enable,
  output logic                    o_slv_cmd_valid [`ICB_SLV_NUM],
  input  logic                    i_slv_cmd_ready [`ICB_SLV_NUM],
  output logic                    o_slv_cmd_read  [`ICB_SLV_NUM],
  output logic [`ICB_AW-1:0]      o_slv_cmd_addr  [`ICB_SLV_NUM],
  output logic [`ICB_DW-1:0]      o_slv_cmd_wdata [`ICB_SLV_NUM],
  output logic [`ICB_MW-1:0]      o_slv_cmd_wmask [`ICB_SLV_NUM],
  output logic                    o_slv_rsp_ready [`ICB_SLV_NUM],
  input  logic                    i_slv_rsp_valid [`ICB_SLV_NUM],
  input  logic [`ICB_DW-1:0]      i_slv_rsp_rdata [`ICB_SLV_NUM],
  input  logic                    i_slv_rsp_err   [`ICB_SLV_NUM],
  output logic                    o_active
);

  icb_cmd_t in_cmd;
  icb_cmd_t buf_cmd;
  logic     buf_cmd_valid;
  logic     buf_cmd_ready;
  logic     cmd_full;
  slv_sel_t buf_sel;
  icb_rsp_t splt_rsp;
  icb_rsp_t out_rsp;
  logic     splt_rsp_valid;
  logic     splt_rsp_ready;
  logic     rsp_full;
  logic     splt_busy;

  assign in_cmd = '{read:  i_icb_cmd_read,
                    addr:  i_icb_cmd_addr,
                    wdata: i_icb_cmd_wdata,
                    wmask: i_icb_cmd_wmask};

  icb_pipe_stage #(.PAYLOAD_T(icb_cmd_t)) cmd_stage_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_icb_cmd_valid),
    .o_ready (o_icb_cmd_ready),
    .i_data  (in_cmd),
    .o_valid (buf_cmd_valid),
    .i_ready (buf_cmd_ready),
    .o_data  (buf_cmd),
    .o_full  (cmd_full)
  );

  icb_addr_decode addr_decode_i (
    .i_addr       (buf_cmd.addr),
    .i_slv_enable (i_slv_enable),
    .o_sel        (buf_sel)
  );

  icb_splt splt_i (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_cmd_valid     (buf_cmd_valid),
    .o_cmd_ready     (buf_cmd_ready),
    .i_cmd           (buf_cmd),
    .i_sel           (buf_sel),
    .o_rsp_valid     (splt_rsp_valid),
    .i_rsp_ready     (splt_rsp_ready),
    .o_rsp           (splt_rsp),
    .o_slv_cmd_valid (o_slv_cmd_valid),
    .i_slv_cmd_ready (i_slv_cmd_ready),
    .o_slv_cmd_read  (o_slv_cmd_read),
    .o_slv_cmd_addr  (o_slv_cmd_addr),
    .o_slv_cmd_wdata (o_slv_cmd_wdata),
    .o_slv_cmd_wmask (o_slv_cmd_wmask),
    .o_slv_rsp_ready (o_slv_rsp_ready),
    .i_slv_rsp_valid (i_slv_rsp_valid),
    .i_slv_rsp_rdata (i_slv_rsp_rdata),
    .i_slv_rsp_err   (i_slv_rsp_err),
    .o_busy          (splt_busy)
  );

  icb_pipe_stage #(.PAYLOAD_T(icb_rsp_t)) rsp_stage_i (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_valid (splt_rsp_valid),
    .o_ready (splt_rsp_ready),
    .i_data  (splt_rsp),
    .o_valid (o_icb_rsp_valid),
    .i_ready (i_icb_rsp_ready),
    .o_data  (out_rsp),
    .o_full  (rsp_full)
  );

  assign o_icb_rsp_rdata = out_rsp.rdata;
  assign o_icb_rsp_err   = out_rsp.err;

  // Something is held in a buffer or still awaits its response
  assign o_active = cmd_full | rsp_full | splt_busy;

endmodule

// ==== verif/icb_slv_model.sv ====
// ICB slave responder
// Accepts commands with random stalls and answers them in order.
// rdata carries the port number on top and the command address below,
// err is set only for writes on port 3
`timescale 1ns/1ps
`include "icb_bus_macros.svh"

module icb_slv_model #(
  parameter int PORT = 0
) (
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_cmd_valid,
  output logic               o_cmd_ready,
  input  logic               i_cmd_read,
  input  logic [`ICB_AW-1:0] i_cmd_addr,
  output logic               o_rsp_valid,
  input  logic               i_rsp_ready,
  output logic [`ICB_DW-1:0] o_rsp_rdata,
  output logic               o_rsp_err
);

  // Pending responses as {rdata, err}
  logic [`ICB_DW:0] pend_q [$];

  always @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_cmd_ready <= 1'b0;
      o_rsp_valid <= 1'b0;
      o_rsp_rdata <= '0;
      o_rsp_err   <= 1'b0;
      pend_q.delete();
    end else begin
      o_cmd_ready <= ($urandom % 4) != 0;
      if (i_cmd_valid && o_cmd_ready) begin
        pend_q.push_back({8'(PORT), 24'h0, i_cmd_addr, (PORT == 3) && !i_cmd_read});
      end
      // A held response stays until it is taken
      if (!o_rsp_valid || i_rsp_ready) begin
        if (pend_q.size() > 0 && ($urandom % 4) != 0) begin
          {o_rsp_rdata, o_rsp_err} <= pend_q.pop_front();
          o_rsp_valid <= 1'b1;
        end else begin
          o_rsp_valid <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== verif/icb_1to4_bus_asserts.sv ====
// ICB splitter handshake checks
// One slave command valid at a time, held responses stay stable,
// and no command is handed out while two responses are still pending
`timescale 1ns/1ps
`include "icb_bus_macros.svh"

module icb_1to4_bus_asserts
  import icb_bus_pkg::*;
(
  input logic     clk,
  input logic     i_rst_n,
  input logic     i_slv_cmd_valid [`ICB_SLV_NUM],
  input logic     i_slv_cmd_ready [`ICB_SLV_NUM],
  input logic     i_rsp_valid,
  input logic     i_rsp_ready,
  input icb_rsp_t i_rsp
);

  slv_sel_t cmd_valid_vec;
  logic     slv_push;
  logic     rsp_pop;
  int       pend_cnt;

  always_comb begin
    slv_push = 1'b0;
    for (int k = 0; k < `ICB_SLV_NUM; k++) begin
      cmd_valid_vec[k] = i_slv_cmd_valid[k];
      slv_push         = slv_push | (i_slv_cmd_valid[k] & i_slv_cmd_ready[k]);
    end
  end

  assign rsp_pop = i_rsp_valid & i_rsp_ready;

  // Commands taken by a slave whose response has not left yet
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pend_cnt <= 0;
    end else begin
      pend_cnt <= pend_cnt + int'(slv_push) - int'(rsp_pop);
    end
  end

  a_one_cmd_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
    $onehot0(cmd_valid_vec))
    else $error("More than one slave port sees a valid command");

  a_rsp_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_rsp_valid && !i_rsp_ready |=> i_rsp_valid && $stable(i_rsp))
    else $error("Response dropped or changed while not ready");

  a_no_full_push: assert property (@(posedge clk) disable iff (!i_rst_n)
    slv_push |-> pend_cnt < `ICB_OUTS_DEPTH)
    else $error("Command pushed into a full pending queue");

endmodule

bind icb_splt icb_1to4_bus_asserts asserts_i (
  .clk             (clk),
  .i_rst_n         (i_rst_n),
  .i_slv_cmd_valid (o_slv_cmd_valid),
  .i_slv_cmd_ready (i_slv_cmd_ready),
  .i_rsp_valid     (o_rsp_valid),
  .i_rsp_ready     (i_rsp_ready),
  .i_rsp           (o_rsp)
);

// ==== verif/icb_1to4_bus_tb.sv ====
// ICB 1-to-4 bus testbench
// Sends a table of commands through the bus, checks where each one lands
// and that responses return in command order with the responder's values
`timescale 1ns/1ps
`include "icb_bus_macros.svh"

module icb_1to4_bus_tb
  import icb_bus_pkg::*;
();

  localparam int TIMEOUT = 200;

  typedef struct {
    icb_cmd_t           cmd;
    logic [2:0]         en;
    int                 port;
    logic [`ICB_DW-1:0] rdata;
    logic               err;
  } row_t;

  logic                    clk;
  logic                    i_rst_n;
  logic                    i_icb_cmd_valid;
  logic                    o_icb_cmd_ready;
  logic                    i_icb_cmd_read;
  logic [`ICB_AW-1:0]      i_icb_cmd_addr;
  logic [`ICB_DW-1:0]      i_icb_cmd_wdata;
  logic [`ICB_MW-1:0]      i_icb_cmd_wmask;
  logic                    o_icb_rsp_valid;
  logic                    i_icb_rsp_ready;
  logic [`ICB_DW-1:0]      o_icb_rsp_rdata;
  logic                    o_icb_rsp_err;
  logic [`ICB_SLV_NUM-2:0] i_slv_enable;
  logic                    o_slv_cmd_valid [`ICB_SLV_NUM];
  logic                    i_slv_cmd_ready [`ICB_SLV_NUM];
  logic                    o_slv_cmd_read  [`ICB_SLV_NUM];
  logic [`ICB_AW-1:0]      o_slv_cmd_addr  [`ICB_SLV_NUM];
  logic [`ICB_DW-1:0]      o_slv_cmd_wdata [`ICB_SLV_NUM];
  logic [`ICB_MW-1:0]      o_slv_cmd_wmask [`ICB_SLV_NUM];
  logic                    o_slv_rsp_ready [`ICB_SLV_NUM];
  logic                    i_slv_rsp_valid [`ICB_SLV_NUM];
  logic [`ICB_DW-1:0]      i_slv_rsp_rdata [`ICB_SLV_NUM];
  logic                    i_slv_rsp_err   [`ICB_SLV_NUM];
  logic                    o_active;

  row_t     rows [$];
  int       arr_port [$];
  icb_cmd_t arr_cmd [$];
  int       rsp_port [$];
  int       test_cnt;
  int       fail_cnt;
  int       error_cnt;
  int       errs_at_start;

  icb_1to4_bus dut_i (.*);

  for (genvar k = 0; k < `ICB_SLV_NUM; k++) begin : slv_g
    icb_slv_model #(.PORT(k)) slv_i (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_cmd_valid (o_slv_cmd_valid[k]),
      .o_cmd_ready (i_slv_cmd_ready[k]),
      .i_cmd_read  (o_slv_cmd_read[k]),
      .i_cmd_addr  (o_slv_cmd_addr[k]),
      .o_rsp_valid (i_slv_rsp_valid[k]),
      .i_rsp_ready (o_slv_rsp_ready[k]),
      .o_rsp_rdata (i_slv_rsp_rdata[k]),
      .o_rsp_err   (i_slv_rsp_err[k])
    );
  end

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Record every command as it is taken by a slave, and every slave response taken
  always @(posedge clk) begin
    for (int k = 0; k < `ICB_SLV_NUM; k++) begin
      if (o_slv_cmd_valid[k] && i_slv_cmd_ready[k]) begin
        arr_port.push_back(k);
        arr_cmd.push_back({o_slv_cmd_read[k], o_slv_cmd_addr[k],
                           o_slv_cmd_wdata[k], o_slv_cmd_wmask[k]});
      end
      if (o_slv_rsp_ready[k] && i_slv_rsp_valid[k]) begin
        rsp_port.push_back(k);
      end
    end
  end

  function automatic void add_row(logic rd, logic [`ICB_AW-1:0] addr,
                                  logic [`ICB_DW-1:0] wdata, logic [`ICB_MW-1:0] wmask,
                                  logic [2:0] en, int port);
    row_t r;
    r.cmd = '{read: rd, addr: addr, wdata: wdata, wmask: wmask};
    r.en = en;
    r.port = port;
    // Responder rule
    r.rdata = {8'(port), 24'h0, addr};
    r.err = (port == 3) && !rd;
    rows.push_back(r);
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      error_cnt++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR: %s", msg);
    error_cnt++;
  endtask

  task automatic send_rows(input int first, input int last);
    int wait_cnt;
    for (int idx = first; idx <= last; idx++) begin
      i_icb_cmd_valid <= 1'b1;
      i_icb_cmd_read  <= rows[idx].cmd.read;
      i_icb_cmd_addr  <= rows[idx].cmd.addr;
      i_icb_cmd_wdata <= rows[idx].cmd.wdata;
      i_icb_cmd_wmask <= rows[idx].cmd.wmask;
      i_slv_enable    <= rows[idx].en;
      wait_cnt = 0;
      do begin
        @(posedge clk);
        wait_cnt++;
      end while (!o_icb_cmd_ready && wait_cnt < TIMEOUT);
      if (!o_icb_cmd_ready) begin
        report_failure($sformatf("command of row %0d was never accepted", idx));
        break;
      end
    end
    i_icb_cmd_valid <= 1'b0;
  endtask

  task automatic collect_rows(input int first, input int last, input int hold);
    int wait_cnt;
    if (hold > 0) begin
      i_icb_rsp_ready <= 1'b0;
      for (int cyc = 1; cyc <= hold; cyc++) begin
        @(posedge clk);
        if (cyc >= 2) begin
          check_value("o_active", 64'(o_active), 64'd1);
        end
      end
      check_value("o_icb_cmd_ready", 64'(o_icb_cmd_ready), 64'd0);
    end
    i_icb_rsp_ready <= 1'b1;
    for (int idx = first; idx <= last; idx++) begin
      wait_cnt = 0;
      do begin
        @(posedge clk);
        wait_cnt++;
      end while (!o_icb_rsp_valid && wait_cnt < TIMEOUT);
      if (!o_icb_rsp_valid) begin
        report_failure($sformatf("no response arrived for row %0d", idx));
        break;
      end
      check_value("o_icb_rsp_rdata", o_icb_rsp_rdata, rows[idx].rdata);
      check_value("o_icb_rsp_err", 64'(o_icb_rsp_err), 64'(rows[idx].err));
    end
  endtask

  task automatic check_arrivals(input int first, input int last);
    icb_cmd_t got;
    int       port;
    int       rsp_k;
    for (int idx = first; idx <= last; idx++) begin
      if (arr_port.size() == 0) begin
        report_failure($sformatf("command of row %0d never reached a slave port", idx));
        break;
      end
      if (rsp_port.size() == 0) begin
        report_failure($sformatf("response of row %0d was never taken from a slave", idx));
        break;
      end
      port  = arr_port.pop_front();
      got   = arr_cmd.pop_front();
      rsp_k = rsp_port.pop_front();
      check_value("slave port", 64'(port), 64'(rows[idx].port));
      check_value("o_slv_cmd_read", 64'(got.read), 64'(rows[idx].cmd.read));
      check_value("o_slv_cmd_addr", 64'(got.addr), 64'(rows[idx].cmd.addr));
      check_value("o_slv_cmd_wdata", got.wdata, rows[idx].cmd.wdata);
      check_value("o_slv_cmd_wmask", 64'(got.wmask), 64'(rows[idx].cmd.wmask));
      check_value("o_slv_rsp_ready", 64'(rsp_k), 64'(rows[idx].port));
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (error_cnt == errs_before) begin
      $display("Test %0d (%s) passed", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("Test %0d (%s) failed with %0d errors", test_cnt, name,
               error_cnt - errs_before);
    end
  endtask

  task automatic run_group(input string name, input int first, input int last,
                           input int hold);
    int errs_before;
    errs_before = error_cnt;
    arr_port.delete();
    arr_cmd.delete();
    rsp_port.delete();
    @(posedge clk);
    fork
      send_rows(first, last);
      collect_rows(first, last, hold);
    join
    check_arrivals(first, last);
    report_test(name, errs_before);
  endtask

  initial begin
    void'($urandom(32'h697b));
    i_rst_n         <= 1'b0;
    i_icb_cmd_valid <= 1'b0;
    i_icb_cmd_read  <= 1'b0;
    i_icb_cmd_addr  <= '0;
    i_icb_cmd_wdata <= '0;
    i_icb_cmd_wmask <= '0;
    i_icb_rsp_ready <= 1'b1;
    i_slv_enable    <= 3'b111;

    // Routing with all ports enabled
    add_row(1'b1, 32'h1000_0010, 64'h0, 8'h00, 3'b111, 0);
    add_row(1'b0, 32'h2000_0ff8, 64'ha5a5_0001_dead_beef, 8'h0f, 3'b111, 1);
    add_row(1'b1, 32'h3000_0100, 64'h0, 8'h00, 3'b111, 2);
    add_row(1'b0, 32'h1000_1000, 64'h0123_4567_89ab_cdef, 8'hff, 3'b111, 3);
    // Disabled regions fall through to port 3
    add_row(1'b0, 32'h1000_0020, 64'h1111_2222_3333_4444, 8'hf0, 3'b110, 3);
    add_row(1'b1, 32'h2000_0040, 64'h0, 8'h00, 3'b110, 1);
    add_row(1'b0, 32'h3000_0080, 64'h5555_6666_7777_8888, 8'h3c, 3'b011, 3);
    // Mixed burst
    add_row(1'b0, 32'h3000_0000, 64'hcafe_0000_0000_0007, 8'h01, 3'b111, 2);
    add_row(1'b1, 32'h1000_0ff0, 64'h0, 8'h00, 3'b111, 0);
    add_row(1'b1, 32'h1000_0ff4, 64'h0, 8'h00, 3'b111, 0);
    add_row(1'b0, 32'h5000_0000, 64'hffff_0000_ffff_0000, 8'haa, 3'b111, 3);
    add_row(1'b1, 32'h2000_0000, 64'h0, 8'h00, 3'b111, 1);
    add_row(1'b0, 32'h0000_0100, 64'h0f0f_0f0f_f0f0_f0f0, 8'h55, 3'b111, 3);
    // Burst under response back-pressure
    add_row(1'b1, 32'h1000_0100, 64'h0, 8'h00, 3'b111, 0);
    add_row(1'b0, 32'h2000_0200, 64'h0000_0000_0000_0014, 8'h0f, 3'b111, 1);
    add_row(1'b1, 32'h3000_0300, 64'h0, 8'h00, 3'b111, 2);
    add_row(1'b0, 32'h6000_0000, 64'h1234_5678_9abc_def0, 8'hff, 3'b111, 3);
    add_row(1'b1, 32'h1000_0400, 64'h0, 8'h00, 3'b111, 0);

    repeat (8) @(posedge clk);
    i_rst_n <= 1'b1;
    @(posedge clk);
    errs_at_start = error_cnt;
    check_value("o_icb_rsp_valid", 64'(o_icb_rsp_valid), 64'd0);
    check_value("o_active", 64'(o_active), 64'd0);
    for (int k = 0; k < `ICB_SLV_NUM; k++) begin
      check_value($sformatf("o_slv_cmd_valid[%0d]", k), 64'(o_slv_cmd_valid[k]), 64'd0);
    end
    report_test("reset state", errs_at_start);

    run_group("port routing", 0, 3, 0);
    run_group("port 0 disabled", 4, 5, 0);
    run_group("port 2 disabled", 6, 6, 0);
    run_group("mixed burst", 7, 12, 0);
    run_group("response back-pressure", 13, 17, 40);

    $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
src/icb_bus_pkg.sv
src/icb_pipe_stage.sv
src/icb_addr_decode.sv
src/icb_splt.sv
src/icb_1to4_bus.sv
verif/icb_slv_model.sv
verif/icb_1to4_bus_asserts.sv
verif/icb_1to4_bus_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ICB 1-to-4 bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module icb_1to4_bus_tb
./obj_dir/Vicb_1to4_bus_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
